/* cpu_bus_pkg.sv */
`default_nettype none

package cpu_bus_pkg;

  // One transfer request from the core to the serializer
  typedef struct packed {
    logic        start;  // One-cycle launch strobe
    logic        write;  // 1 = store, 0 = fetch or load
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // Serializer answer back to the core
  typedef struct packed {
    logic        busy;   // High from header beat to last data beat
    logic        done;   // One cycle after the last data beat
    logic [31:0] rdata;  // Valid while done is high
  } bus_rsp_t;

  // Code 0 and every unlisted code decode as a no-op
  typedef enum logic [3:0] {
    OP_LOAD  = 4'h1,
    OP_STORE = 4'h2,
    OP_ADDI  = 4'h3,
    OP_JUMP  = 4'h4,
    OP_HALT  = 4'h5
  } opcode_e;

  // Memory view, used by LOAD, STORE and JUMP
  typedef struct packed {
    opcode_e     opcode;
    logic [1:0]  reg_idx;
    logic [1:0]  spare;
    logic [23:0] addr;     // Byte address in the low 24 bits of the bus
  } instr_mem_t;

  // Immediate view, used by ADDI
  typedef struct packed {
    opcode_e            opcode;
    logic [1:0]         reg_idx;
    logic [1:0]         spare;
    logic signed [23:0] imm;
  } instr_imm_t;

  // One instruction word, read either way
  typedef union packed {
    instr_mem_t mem;
    instr_imm_t im;
  } instr_u;

  // Header beat that opens every transfer on uo_out
  localparam logic [7:0] HDR_READ  = 8'hA0;
  localparam logic [7:0] HDR_WRITE = 8'hA1;

endpackage

`default_nettype wire

/* bus_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_serializer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cpu_bus_pkg::bus_req_t req,
  output cpu_bus_pkg::bus_rsp_t rsp,
  output logic [7:0]            uo_out,
  output logic [7:0]            uio_out,
  output logic [7:0]            uio_oe,
  input  logic [7:0]            uio_in
);

  import cpu_bus_pkg::*;

  localparam logic [3:0] FIRST_ADDR_BEAT = 4'd1;
  localparam logic [3:0] LAST_ADDR_BEAT  = 4'd4;
  localparam logic [3:0] FIRST_DATA_BEAT = 4'd5;
  localparam logic [3:0] LAST_BEAT       = 4'd8;

  logic        busy_q;
  logic        done_q;
  logic [3:0]  beat_q;
  logic        write_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;
  logic [1:0]  lane;
  logic        accept;
  logic        addr_beat;
  logic        data_beat;

  // Beats 1..4 and 5..8 both map to byte lanes 0..3
  assign lane = beat_q[1:0] - 2'd1;

  assign accept    = !busy_q && req.start;
  assign addr_beat = busy_q && (beat_q >= FIRST_ADDR_BEAT) && (beat_q <= LAST_ADDR_BEAT);
  assign data_beat = busy_q && (beat_q >= FIRST_DATA_BEAT);

  // Beat counter and transfer state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      beat_q  <= 4'd0;
      write_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q  <= 1'b1;          // Header goes out next cycle
        beat_q  <= 4'd0;
        write_q <= req.write;
      end else if (busy_q) begin
        if (beat_q == LAST_BEAT) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;         // Read word complete
          beat_q <= 4'd0;
        end else begin
          beat_q <= beat_q + 4'd1;
        end
      end
    end
  end

  // Address and data words, captured once per transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
    end
    if (data_beat && !write_q) begin
      rdata_q[8*lane +: 8] <= uio_in;  // LSB first, sampled at end of beat
    end
  end

  // Pin multiplexer
  always_comb begin
    uo_out = 8'h00;
    if (busy_q && beat_q == 4'd0) begin
      uo_out = write_q ? HDR_WRITE : HDR_READ;
    end else if (addr_beat) begin
      uo_out = addr_q[8*lane +: 8];
    end
  end

  assign uio_out = (data_beat && write_q) ? wdata_q[8*lane +: 8] : 8'h00;
  assign uio_oe  = (data_beat && write_q) ? 8'hFF : 8'h00;  // Drive only on write data

  assign rsp.busy  = busy_q;
  assign rsp.done  = done_q;
  assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

/* cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  output cpu_bus_pkg::bus_req_t req,
  input  cpu_bus_pkg::bus_rsp_t rsp
);

  import cpu_bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_DATA,
    ST_HALTED
  } state_e;

  state_e      state_q;
  state_e      state_d;
  logic [31:0] pc_q;
  logic [31:0] pc_d;
  logic [31:0] pc_inc;
  instr_u      instr_q;
  logic [31:0] regs [4];
  logic [1:0]  reg_idx;
  logic [31:0] mem_addr;
  logic [31:0] imm_ext;

  logic        instr_end;
  logic        launch;
  logic        launch_write;
  logic [31:0] launch_addr;
  logic [31:0] launch_wdata;
  logic        rf_we;
  logic [31:0] rf_wdata;

  logic        start_q;
  logic        write_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;

  assign reg_idx  = instr_q.mem.reg_idx;
  assign mem_addr = {8'h00, instr_q.mem.addr};
  assign imm_ext  = {{8{instr_q.im.imm[23]}}, instr_q.im.imm};  // Sign extend
  assign pc_inc   = pc_q + 32'd4;

  always_comb begin
    state_d      = state_q;
    pc_d         = pc_q;
    instr_end    = 1'b0;
    launch       = 1'b0;
    launch_write = 1'b0;
    launch_addr  = pc_q;
    launch_wdata = 32'h0;
    rf_we        = 1'b0;
    rf_wdata     = rsp.rdata;

    case (state_q)
      ST_IDLE: begin
        if (run && !rsp.busy) begin
          launch  = 1'b1;             // Fetch at current PC
          state_d = ST_FETCH;
        end
      end
      ST_FETCH: begin
        if (rsp.done) begin
          state_d = ST_DECODE;
        end
      end
      ST_DECODE: begin
        case (instr_q.mem.opcode)
          OP_LOAD: begin
            launch      = 1'b1;
            launch_addr = mem_addr;
            state_d     = ST_DATA;
          end
          OP_STORE: begin
            launch       = 1'b1;
            launch_write = 1'b1;
            launch_addr  = mem_addr;
            launch_wdata = regs[reg_idx];
            state_d      = ST_DATA;
          end
          OP_ADDI: begin
            rf_we     = 1'b1;
            rf_wdata  = regs[reg_idx] + imm_ext;
            pc_d      = pc_inc;
            instr_end = 1'b1;
          end
          OP_JUMP: begin
            pc_d      = mem_addr;
            instr_end = 1'b1;
          end
          OP_HALT: begin
            state_d = ST_HALTED;
          end
          default: begin
            pc_d      = pc_inc;       // Unknown codes fall through
            instr_end = 1'b1;
          end
        endcase
      end
      ST_DATA: begin
        if (rsp.done) begin
          rf_we     = (instr_q.mem.opcode == OP_LOAD);
          pc_d      = pc_inc;
          instr_end = 1'b1;
        end
      end
      default: begin
        state_d = ST_HALTED;          // Stays here until reset
      end
    endcase

    // Next fetch goes out right away unless run is low
    if (instr_end) begin
      if (run) begin
        launch      = 1'b1;
        launch_addr = pc_d;
        state_d     = ST_FETCH;
      end else begin
        state_d = ST_IDLE;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      pc_q    <= RESET_PC;
      start_q <= 1'b0;
      write_q <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        regs[i] <= 32'h0;
      end
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      start_q <= launch;              // One-cycle strobe
      if (launch) begin
        write_q <= launch_write;
      end
      if (rf_we) begin
        regs[reg_idx] <= rf_wdata;
      end
    end
  end

  // Request payload and fetched word
  always_ff @(posedge clk) begin
    if (launch) begin
      addr_q  <= launch_addr;         // Held until done
      wdata_q <= launch_wdata;
    end
    if (state_q == ST_FETCH && rsp.done) begin
      instr_q <= rsp.rdata;
    end
  end

  assign req.start = start_q;
  assign req.write = write_q;
  assign req.addr  = addr_q;
  assign req.wdata = wdata_q;

endmodule

`default_nettype wire

/* cpu_pin_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_pin_bridge #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ena,
  input  logic [7:0] ui_in,
  input  logic [7:0] uio_in,
  output logic [7:0] uo_out,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);

  import cpu_bus_pkg::*;

  bus_req_t bus_req;
  bus_rsp_t bus_rsp;

  cpu_core #(
    .RESET_PC (RESET_PC)
  ) cpu_core_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (ui_in[0]),   // Run level from the tile inputs
    .req   (bus_req),
    .rsp   (bus_rsp)
  );

  // Whole memory bus leaves through the 8-bit pins
  bus_serializer bus_serializer_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (bus_req),
    .rsp     (bus_rsp),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

endmodule

`default_nettype wire

/* cpu_pin_bridge_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_pin_bridge_sva (
  input logic                  clk,
  input logic                  rst_n,
  input cpu_bus_pkg::bus_req_t req,
  input cpu_bus_pkg::bus_rsp_t rsp,
  input logic [7:0]            uo_out,
  input logic [7:0]            uio_oe
);

  logic accept;

  assign accept = req.start && !rsp.busy;            // Serializer takes the request

  a_oe_whole_byte: assert property (@(posedge clk) disable iff (!rst_n)
    (uio_oe == 8'h00) || (uio_oe == 8'hFF))
    else $error("uio_oe is neither all ones nor zero");

  // Ten cycles from start to done in both directions
  a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    $past(accept, 10) |-> rsp.done)
    else $error("done did not follow start after 10 cycles");

  a_done_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.done |-> $past(accept, 10))
    else $error("done pulsed without a start 10 cycles earlier");

  a_idle_pins_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !rsp.busy |-> (uo_out == 8'h00))
    else $error("uo_out is not zero while the serializer is idle");

endmodule

bind bus_serializer cpu_pin_bridge_sva cpu_pin_bridge_sva_inst (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .rsp    (rsp),
  .uo_out (uo_out),
  .uio_oe (uio_oe)
);

`default_nettype wire

/* tb_cpu_pin_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_pin_bridge;

  import cpu_bus_pkg::*;

  localparam int          CLK_PERIOD  = 20;
  localparam int          HDR_TIMEOUT = 60;          // Idle cycles allowed before a header
  localparam logic [31:0] RESET_PC    = 32'h0000_0000;

  logic       clk;
  logic       rst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  logic [31:0] mem [256];                             // Word memory behind the pins
  logic [7:0]  log_hdr [$];
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];

  int seed            = 32'hb8d72591;
  int checks          = 0;
  int value_errors    = 0;
  int protocol_errors = 0;

  cpu_pin_bridge cpu_pin_bridge_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ena     (ena),
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_header(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_pins(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_problem(input string what);
    protocol_errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  function automatic logic [31:0] mem_instr(opcode_e op, logic [1:0] rd, logic [23:0] addr);
    instr_u word;
    word             = '0;
    word.mem.opcode  = op;
    word.mem.reg_idx = rd;
    word.mem.addr    = addr;
    return word;
  endfunction

  function automatic logic [31:0] imm_instr(logic [1:0] rd, logic signed [23:0] imm);
    instr_u word;
    word            = '0;
    word.im.opcode  = OP_ADDI;
    word.im.reg_idx = rd;
    word.im.imm     = imm;
    return word;
  endfunction

  task automatic drive_run(input logic level);
    @(posedge clk);
    #2;
    ui_in = {7'b0, level};
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    ui_in  = 8'h00;
    uio_in = 8'h00;
    rst_n  = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  // Opcode nibble stays 0, so unwritten words run as no-ops
  task automatic clear_memory();
    for (int i = 0; i < 256; i++) begin
      mem[i] = {24'h0, i[7:0]};
    end
    log_hdr.delete();
    log_addr.delete();
    log_data.delete();
  endtask

  // One transfer seen from the memory side of the pins
  task automatic serve_transfer(output bit ok);
    logic [7:0]  hdr;
    logic [31:0] addr;
    logic [31:0] data;
    int          waited;
    ok     = 1'b0;
    addr   = 32'h0;
    data   = 32'h0;
    waited = 0;
    @(negedge clk);
    while (uo_out == 8'h00 && waited < HDR_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    hdr = uo_out;
    if (hdr == 8'h00) begin
      report_problem("no transfer header appeared before the timeout");
      return;
    end
    if (hdr != HDR_READ && hdr != HDR_WRITE) begin
      report_problem($sformatf("header beat %h is neither read nor write", hdr));
      return;
    end
    for (int b = 0; b < 4; b++) begin
      @(negedge clk);
      addr[8*b +: 8] = uo_out;                        // LSB first
    end
    if (hdr == HDR_WRITE) begin
      for (int b = 0; b < 4; b++) begin
        @(negedge clk);
        compare_pins("uio_oe on write beat", uio_oe, 8'hFF);
        data[8*b +: 8] = uio_out;
      end
      mem[addr[9:2]] = data;
    end else begin
      data = mem[addr[9:2]];
      for (int b = 0; b < 4; b++) begin
        @(posedge clk);
        #2;
        uio_in = data[8*b +: 8];
        @(negedge clk);
        compare_pins("uio_oe on read beat", uio_oe, 8'h00);
      end
    end
    log_hdr.push_back(hdr);
    log_addr.push_back(addr);
    log_data.push_back(data);
    ok = 1'b1;
  endtask

  task automatic run_transfers(input int count);
    bit ok;
    for (int i = 0; i < count; i++) begin
      serve_transfer(ok);
      if (!ok) begin
        report_problem($sformatf("only %0d of %0d transfers completed", i, count));
        return;
      end
    end
  endtask

  task automatic check_transfer(input int idx, input logic [7:0] hdr, input logic [31:0] addr);
    if (idx >= log_hdr.size()) begin
      report_problem($sformatf("transfer %0d never took place", idx));
      return;
    end
    compare_header($sformatf("header of transfer %0d", idx), log_hdr[idx], hdr);
    compare_word($sformatf("address of transfer %0d", idx), log_addr[idx], addr);
  endtask

  task automatic check_data(input int idx, input logic [31:0] data);
    if (idx < log_data.size()) begin
      compare_word($sformatf("data of transfer %0d", idx), log_data[idx], data);
    end
  endtask

  task automatic expect_quiet(input int cycles, input string during);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (uo_out != 8'h00) begin
        report_problem($sformatf("header %h appeared while %s", uo_out, during));
        return;
      end
    end
  endtask

  task automatic test_reset_idle();
    apply_reset();
    @(negedge clk);
    compare_pins("uo_out after reset", uo_out, 8'h00);
    compare_pins("uio_out after reset", uio_out, 8'h00);
    compare_pins("uio_oe after reset", uio_oe, 8'h00);
    expect_quiet(50, "run was low after reset");
  endtask

  task automatic test_fetch_framing();
    clear_memory();
    mem[0] = imm_instr(2'd0, 24'sd1);
    mem[1] = mem_instr(OP_HALT, 2'd0, 24'h0);
    apply_reset();
    drive_run(1'b1);
    run_transfers(2);
    check_transfer(0, HDR_READ, RESET_PC);
    check_transfer(1, HDR_READ, RESET_PC + 32'd4);
    drive_run(1'b0);
  endtask

  task automatic test_load_store();
    logic [31:0] value;
    value = $random(seed);
    clear_memory();
    mem[0]     = mem_instr(OP_LOAD, 2'd1, 24'h000100);
    mem[1]     = mem_instr(OP_STORE, 2'd1, 24'h000180);
    mem[2]     = mem_instr(OP_HALT, 2'd0, 24'h0);
    mem[8'h40] = value;                               // Word at 0x100
    apply_reset();
    drive_run(1'b1);
    run_transfers(5);
    check_transfer(1, HDR_READ, 32'h100);
    check_transfer(2, HDR_READ, 32'h4);
    check_transfer(3, HDR_WRITE, 32'h180);
    check_data(3, value);
    compare_word("memory word at 0x180", mem[8'h60], value);
    drive_run(1'b0);
  endtask

  task automatic test_addi();
    logic [31:0]        value;
    logic [31:0]        rnd;
    logic signed [23:0] imm;
    logic [31:0]        imm_ext;
    value   = $random(seed);
    rnd     = $random(seed);
    imm     = -$signed({8'h00, rnd[15:0]}) - 24'sd1;  // Always negative
    imm_ext = 32'(imm);
    clear_memory();
    mem[0]     = mem_instr(OP_LOAD, 2'd2, 24'h000140);
    mem[1]     = imm_instr(2'd2, imm);
    mem[2]     = mem_instr(OP_STORE, 2'd2, 24'h0001C0);
    mem[3]     = mem_instr(OP_HALT, 2'd0, 24'h0);
    mem[8'h50] = value;
    apply_reset();
    drive_run(1'b1);
    run_transfers(6);
    check_transfer(4, HDR_WRITE, 32'h1C0);
    check_data(4, value + imm_ext);
    drive_run(1'b0);
  endtask

  task automatic test_jump_halt();
    clear_memory();
    mem[0]     = mem_instr(OP_JUMP, 2'd0, 24'h000040);
    mem[8'h10] = mem_instr(OP_HALT, 2'd0, 24'h0);
    apply_reset();
    drive_run(1'b1);
    run_transfers(2);
    check_transfer(1, HDR_READ, 32'h40);
    expect_quiet(100, "the core was halted");
    drive_run(1'b0);
  endtask

  task automatic test_run_pause();
    clear_memory();
    mem[0] = imm_instr(2'd3, 24'sd7);
    mem[1] = mem_instr(OP_STORE, 2'd3, 24'h000100);
    mem[2] = mem_instr(OP_HALT, 2'd0, 24'h0);
    apply_reset();
    drive_run(1'b1);
    run_transfers(1);
    drive_run(1'b0);                                  // Drops during the ADDI fetch done cycle
    expect_quiet(40, "run was held low");
    drive_run(1'b1);
    run_transfers(3);
    check_transfer(1, HDR_READ, 32'h4);
    check_transfer(2, HDR_WRITE, 32'h100);
    check_data(2, 32'd7);
    drive_run(1'b0);
  endtask

  initial begin
    rst_n  = 1'b0;
    ena    = 1'b1;
    ui_in  = 8'h00;
    uio_in = 8'h00;
    test_reset_idle();
    test_fetch_framing();
    test_load_store();
    test_addi();
    test_jump_halt();
    test_run_pause();
    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
cpu_bus_pkg.sv
bus_serializer.sv
cpu_core.sv
cpu_pin_bridge.sv
cpu_pin_bridge_sva.sv
tb_cpu_pin_bridge.sv

/* Makefile */
# Verilator build and run for the pin bridge testbench

VERILATOR  ?= verilator
TOP        ?= tb_cpu_pin_bridge
RTL_TOP    ?= cpu_pin_bridge
FLIST      ?= flist.f
RTL_SRCS   ?= cpu_bus_pkg.sv bus_serializer.sv cpu_core.sv cpu_pin_bridge.sv
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
PASS_MSG   ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
